// File: Makefile
TOP := ex_unit_tb

.PHONY: all compile run clean

all: run

compile: obj_dir/V$(TOP)

obj_dir/V$(TOP): ex_unit.f $(wildcard design/*.sv verif/*.sv)
	verilator --binary --assert -Wno-fatal --top-module $(TOP) -f ex_unit.f -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^Everything OK$$" sim.log

clean:
	rm -rf obj_dir sim.log

// File: design/ex_alu.sv
`default_nettype none

module ex_alu import ex_pkg::*; (
  input  ex_op_e          op_i,
  input  logic [XLEN-1:0] operand_a_i,
  input  logic [XLEN-1:0] operand_b_i,
  output logic [XLEN-1:0] result_o,
  output logic            cmp_result_o
);

  logic            sub_en;
  logic [XLEN:0]   adder_full;
  logic [XLEN-1:0] adder_result;
  logic [4:0]      shamt;
  logic            is_equal;
  logic            less_signed;
  logic            less_unsigned;

  //////////////////////////////////////////////////
  // Shared adder
  //////////////////////////////////////////////////

  // Subtract for SUB, set-less-than and every comparison
  always_comb
  begin
    case (op_i)
      OP_SUB, OP_SLT, OP_SLTU,
      OP_EQ, OP_NE, OP_LT, OP_GE, OP_LTU, OP_GEU: sub_en = 1'b1;
      default:                                    sub_en = 1'b0;
    endcase
  end

  // Subtract as a + ~b + 1 and keep carry out for unsigned compare
  assign adder_full = {1'b0, operand_a_i}
                    + {1'b0, (sub_en ? ~operand_b_i : operand_b_i)}
                    + {{XLEN{1'b0}}, sub_en};
  assign adder_result = adder_full[XLEN-1:0];

  // Borrow means a below b
  assign less_unsigned = ~adder_full[XLEN];
  // Differing signs make the negative one smaller
  assign less_signed = (operand_a_i[XLEN-1] ^ operand_b_i[XLEN-1]) ?
                       operand_a_i[XLEN-1] : adder_result[XLEN-1];
  assign is_equal = (adder_result == '0);

  // Only low 5 bits of b shift
  assign shamt = operand_b_i[4:0];

  //////////////////////////////////////////////////
  // Result select
  //////////////////////////////////////////////////

  always_comb
  begin
    case (op_i)
      OP_AND:  result_o = operand_a_i & operand_b_i;
      OP_OR:   result_o = operand_a_i | operand_b_i;
      OP_XOR:  result_o = operand_a_i ^ operand_b_i;
      OP_SLL:  result_o = operand_a_i << shamt;
      OP_SRL:  result_o = operand_a_i >> shamt;
      OP_SRA:  result_o = $unsigned($signed(operand_a_i) >>> shamt);
      OP_SLT:  result_o = {{(XLEN-1){1'b0}}, less_signed};
      OP_SLTU: result_o = {{(XLEN-1){1'b0}}, less_unsigned};
      // Add, sub and comparisons
      default: result_o = adder_result;
    endcase
  end

  // Branch condition
  always_comb
  begin
    case (op_i)
      OP_EQ:   cmp_result_o = is_equal;
      OP_NE:   cmp_result_o = ~is_equal;
      OP_LT:   cmp_result_o = less_signed;
      OP_GE:   cmp_result_o = ~less_signed;
      OP_LTU:  cmp_result_o = less_unsigned;
      OP_GEU:  cmp_result_o = ~less_unsigned;
      default: cmp_result_o = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

// File: design/ex_pkg.sv
`default_nettype none

package ex_pkg;

  //////////////////////////////////////////////////
  // Widths and sizes
  //////////////////////////////////////////////////

  // Datapath width
  localparam int XLEN = 32;
  // Register file address
  localparam int REG_ADDR_W = 5;
  // One shift-add step per multiplier bit
  localparam int MULT_STEPS = 32;
  localparam int MULT_CNT_W = $clog2(MULT_STEPS);

  //////////////////////////////////////////////////
  // Operation codes
  //////////////////////////////////////////////////

  typedef enum logic [4:0] {
    OP_ADD  = 5'd0,
    OP_SUB  = 5'd1,
    OP_AND  = 5'd2,
    OP_OR   = 5'd3,
    OP_XOR  = 5'd4,
    OP_SLL  = 5'd5,
    OP_SRL  = 5'd6,
    OP_SRA  = 5'd7,
    OP_SLT  = 5'd8,
    OP_SLTU = 5'd9,
    // Branch comparisons
    OP_EQ   = 5'd10,
    OP_NE   = 5'd11,
    OP_LT   = 5'd12,
    OP_GE   = 5'd13,
    OP_LTU  = 5'd14,
    OP_GEU  = 5'd15,
    // Sequential multiply, low word
    OP_MUL  = 5'd16
  } ex_op_e;

  //////////////////////////////////////////////////
  // Stage payloads
  //////////////////////////////////////////////////

  // Decoded operation from issue
  typedef struct packed {
    ex_op_e                op;
    logic [XLEN-1:0]       operand_a;
    logic [XLEN-1:0]       operand_b;
    // Jump target
    logic [XLEN-1:0]       operand_c;
    logic [REG_ADDR_W-1:0] waddr;
    logic                  we;
    logic                  is_branch;
    logic                  csr_access;
    logic [XLEN-1:0]       csr_rdata;
  } ex_issue_t;

  // Write-back request from EX/WB to register file
  typedef struct packed {
    logic                  we;
    logic [REG_ADDR_W-1:0] waddr;
    logic [XLEN-1:0]       wdata;
  } wb_req_t;

endpackage

`default_nettype wire

// File: design/ex_stage.sv
`default_nettype none

module ex_stage import ex_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            issue_valid_i,
  input  ex_issue_t       issue_i,
  input  logic            stall_i,
  output logic            ex_ready_o,
  output logic            ex_valid_o,
  output logic            branch_decision_o,
  output logic [XLEN-1:0] jump_target_o,
  output wb_req_t         wb_o
);

  logic [XLEN-1:0]       alu_result;
  logic                  alu_cmp_result;
  logic [XLEN-1:0]       mult_result;
  logic                  mult_load;
  logic                  mult_step;
  logic                  mult_last;
  logic                  mult_busy;
  logic                  mult_done;
  logic                  mult_idle;
  logic                  is_mul;
  logic                  issue_go;
  logic                  mult_start;
  logic                  alu_fire;
  logic                  mult_fire;
  logic [REG_ADDR_W-1:0] mul_waddr_q;
  logic                  mul_we_q;
  wb_req_t               wb_d;
  wb_req_t               wb_q;

  //////////////////////////////////////////////////
  // ALU
  //////////////////////////////////////////////////

  ex_alu u_alu (
    .op_i         (issue_i.op),
    .operand_a_i  (issue_i.operand_a),
    .operand_b_i  (issue_i.operand_b),
    .result_o     (alu_result),
    .cmp_result_o (alu_cmp_result)
  );

  //////////////////////////////////////////////////
  // Multiplier
  //////////////////////////////////////////////////

  assign is_mul = (issue_i.op == OP_MUL) & ~issue_i.is_branch;
  // New work only when nothing is in flight
  assign mult_idle  = ~mult_busy & ~mult_done;
  assign issue_go   = issue_valid_i & mult_idle & ~stall_i;
  assign mult_start = issue_go & is_mul;

  mult_ctrl u_mult_ctrl (
    .clk     (clk),
    .rst_n   (rst_n),
    .start_i (mult_start),
    .last_i  (mult_last),
    .stall_i (stall_i),
    .load_o  (mult_load),
    .step_o  (mult_step),
    .busy_o  (mult_busy),
    .done_o  (mult_done)
  );

  mult_step_counter u_mult_cnt (
    .clk     (clk),
    .rst_n   (rst_n),
    .clear_i (mult_load),
    .step_i  (mult_step),
    .last_o  (mult_last)
  );

  mult_datapath u_mult_dp (
    .clk       (clk),
    .rst_n     (rst_n),
    .load_i    (mult_load),
    .step_i    (mult_step),
    .op_a_i    (issue_i.operand_a),
    .op_b_i    (issue_i.operand_b),
    .product_o (mult_result)
  );

  // Multiply destination kept since upstream moves on after accept
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      mul_waddr_q <= '0;
      mul_we_q    <= 1'b0;
    end
    else if (mult_load)
    begin
      mul_waddr_q <= issue_i.waddr;
      mul_we_q    <= issue_i.we;
    end
  end

  //////////////////////////////////////////////////
  // Handshake and branch
  //////////////////////////////////////////////////

  // Branches finish without write-back
  assign ex_ready_o = (mult_idle & ~stall_i)
                    | (issue_valid_i & issue_i.is_branch);

  assign alu_fire   = issue_go & ~is_mul;
  assign mult_fire  = mult_done & ~stall_i;
  // Independent of ex_ready_o
  assign ex_valid_o = alu_fire | mult_fire;

  assign branch_decision_o = issue_valid_i & issue_i.is_branch & alu_cmp_result;
  assign jump_target_o     = issue_i.operand_c;

  //////////////////////////////////////////////////
  // Result mux and EX/WB register
  //////////////////////////////////////////////////

  // Priority multiply, CSR, ALU
  always_comb
  begin
    if (mult_done)
    begin
      wb_d.we    = mul_we_q;
      wb_d.waddr = mul_waddr_q;
      wb_d.wdata = mult_result;
    end
    else
    begin
      wb_d.we    = issue_i.we & ~issue_i.is_branch;
      wb_d.waddr = issue_i.waddr;
      wb_d.wdata = issue_i.csr_access ? issue_i.csr_rdata : alu_result;
    end
  end

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
      wb_q <= '0;
    else if (ex_valid_o)
      wb_q <= wb_d;
    else if (!stall_i)
      // Bubble with nothing to write
      wb_q.we <= 1'b0;
  end

  assign wb_o = wb_q;

endmodule

`default_nettype wire

// File: design/ex_unit_top.sv
`default_nettype none

module ex_unit_top import ex_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  issue_valid_i,
  input  ex_issue_t             issue_i,
  input  logic                  stall_i,
  output logic                  ex_ready_o,
  output logic                  ex_valid_o,
  output logic                  branch_decision_o,
  output logic [XLEN-1:0]       jump_target_o,
  input  logic [REG_ADDR_W-1:0] raddr_i,
  output logic [XLEN-1:0]       rdata_o
);

  // EX/WB to register file
  wb_req_t wb_req;

  ex_stage u_ex_stage (
    .clk               (clk),
    .rst_n             (rst_n),
    .issue_valid_i     (issue_valid_i),
    .issue_i           (issue_i),
    .stall_i           (stall_i),
    .ex_ready_o        (ex_ready_o),
    .ex_valid_o        (ex_valid_o),
    .branch_decision_o (branch_decision_o),
    .jump_target_o     (jump_target_o),
    .wb_o              (wb_req)
  );

  wb_regfile u_regfile (
    .clk     (clk),
    .rst_n   (rst_n),
    .wb_i    (wb_req),
    .raddr_i (raddr_i),
    .rdata_o (rdata_o)
  );

endmodule

`default_nettype wire

// File: design/mult_ctrl.sv
`default_nettype none

module mult_ctrl (
  input  logic clk,
  input  logic rst_n,
  input  logic start_i,
  input  logic last_i,
  input  logic stall_i,
  output logic load_o,
  output logic step_o,
  output logic busy_o,
  output logic done_o
);

  typedef enum logic [1:0] {
    MC_IDLE,
    MC_BUSY,
    MC_DONE
  } mc_state_e;

  mc_state_e state_q;
  mc_state_e state_d;

  // Next state and strobes
  always_comb
  begin
    state_d = state_q;
    load_o  = 1'b0;
    step_o  = 1'b0;
    case (state_q)
      MC_IDLE:
      begin
        // Operands loaded on the accepting edge
        if (start_i)
        begin
          load_o  = 1'b1;
          state_d = MC_BUSY;
        end
      end
      MC_BUSY:
      begin
        step_o = 1'b1;
        if (last_i)
          state_d = MC_DONE;
      end
      MC_DONE:
      begin
        // Result waits here for downstream
        if (!stall_i)
          state_d = MC_IDLE;
      end
      default: state_d = MC_IDLE;
    endcase
  end

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
      state_q <= MC_IDLE;
    else
      state_q <= state_d;
  end

  assign done_o = (state_q == MC_DONE);
  // Finished but blocked counts as busy
  assign busy_o = (state_q == MC_BUSY) | (done_o & stall_i);

endmodule

`default_nettype wire

// File: design/mult_datapath.sv
`default_nettype none

module mult_datapath import ex_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            load_i,
  input  logic            step_i,
  input  logic [XLEN-1:0] op_a_i,
  input  logic [XLEN-1:0] op_b_i,
  output logic [XLEN-1:0] product_o
);

  // Only the low word is kept so XLEN bits are enough everywhere
  logic [XLEN-1:0] mcand_q;
  logic [XLEN-1:0] mplier_q;
  logic [XLEN-1:0] acc_q;
  logic [XLEN-1:0] acc_add;

  // Partial product for this bit
  assign acc_add = mplier_q[0] ? (acc_q + mcand_q) : acc_q;

  //////////////////////////////////////////////////
  // Shift-add registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      mcand_q  <= '0;
      mplier_q <= '0;
      acc_q    <= '0;
    end
    else if (load_i)
    begin
      mcand_q  <= op_a_i;
      mplier_q <= op_b_i;
      acc_q    <= '0;
    end
    else if (step_i)
    begin
      acc_q    <= acc_add;
      // Multiplicand moves up and multiplier down
      mcand_q  <= mcand_q << 1;
      mplier_q <= mplier_q >> 1;
    end
  end

  assign product_o = acc_q;

endmodule

`default_nettype wire

// File: design/mult_step_counter.sv
`default_nettype none

module mult_step_counter import ex_pkg::*; (
  input  logic clk,
  input  logic rst_n,
  input  logic clear_i,
  input  logic step_i,
  output logic last_o
);

  logic [MULT_CNT_W-1:0] count_q;

  // Restart on load, one tick per step
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
      count_q <= '0;
    else if (clear_i)
      count_q <= '0;
    else if (step_i)
      count_q <= count_q + 1'b1;
  end

  // Final step in progress
  assign last_o = step_i & (count_q == MULT_CNT_W'(MULT_STEPS - 1));

endmodule

`default_nettype wire

// File: design/wb_regfile.sv
`default_nettype none

module wb_regfile import ex_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  wb_req_t               wb_i,
  input  logic [REG_ADDR_W-1:0] raddr_i,
  output logic [XLEN-1:0]       rdata_o
);

  localparam int NREGS = 2 ** REG_ADDR_W;

  // x0 has no storage
  logic [XLEN-1:0] regs_q [1:NREGS-1];

  // Single write port
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int i = 1; i < NREGS; i++)
        regs_q[i] <= '0;
    end
    else if (wb_i.we && (wb_i.waddr != '0))
    begin
      regs_q[wb_i.waddr] <= wb_i.wdata;
    end
  end

  // Combinational read with x0 tied to zero
  assign rdata_o = (raddr_i == '0) ? '0 : regs_q[raddr_i];

endmodule

`default_nettype wire

// File: ex_unit.f
design/ex_pkg.sv
design/ex_alu.sv
design/mult_ctrl.sv
design/mult_step_counter.sv
design/mult_datapath.sv
design/ex_stage.sv
design/wb_regfile.sv
design/ex_unit_top.sv
verif/ex_unit_tb.sv

// File: verif/ex_unit_tb.sv
`default_nettype none

module ex_unit_tb import ex_pkg::*; ();

  localparam int CLK_PERIOD    = 40;
  localparam int DRIVE_DLY     = 4;
  localparam int RESET_CYCLES  = 16;
  localparam int READY_TIMEOUT = 100;
  localparam int NUM_REGS      = 2 ** REG_ADDR_W;

  localparam ex_op_e ALU_OPS [10] = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
                                      OP_SLL, OP_SRL, OP_SRA, OP_SLT, OP_SLTU};
  localparam ex_op_e CMP_OPS [6]  = '{OP_EQ, OP_NE, OP_LT, OP_GE, OP_LTU, OP_GEU};

  logic                  clk;
  logic                  rst_n;
  logic                  issue_valid_i;
  ex_issue_t             issue_i;
  logic                  stall_i;
  logic                  ex_ready_o;
  logic                  ex_valid_o;
  logic                  branch_decision_o;
  logic [XLEN-1:0]       jump_target_o;
  logic [REG_ADDR_W-1:0] raddr_i;
  logic [XLEN-1:0]       rdata_o;

  // Expected register file contents
  logic [XLEN-1:0] model_regs [NUM_REGS];
  integer          seed = 47;
  int              errors;
  int              test_start_errors;
  int              tests_passed;
  int              tests_failed;
  logic            timed_out;

  ex_unit_top uut (
    .clk               (clk),
    .rst_n             (rst_n),
    .issue_valid_i     (issue_valid_i),
    .issue_i           (issue_i),
    .stall_i           (stall_i),
    .ex_ready_o        (ex_ready_o),
    .ex_valid_o        (ex_valid_o),
    .branch_decision_o (branch_decision_o),
    .jump_target_o     (jump_target_o),
    .raddr_i           (raddr_i),
    .rdata_o           (rdata_o)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  //////////////////////////////////////////////////
  // Reference rules
  //////////////////////////////////////////////////

  function automatic logic [XLEN-1:0] alu_ref(input ex_op_e op, input logic [XLEN-1:0] a,
                                              input logic [XLEN-1:0] b);
    case (op)
      OP_ADD:  return a + b;
      OP_AND:  return a & b;
      OP_OR:   return a | b;
      OP_XOR:  return a ^ b;
      // Shift amount is b[4:0]
      OP_SLL:  return a << b[4:0];
      OP_SRL:  return a >> b[4:0];
      OP_SRA:  return $unsigned($signed(a) >>> b[4:0]);
      OP_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      OP_SLTU: return (a < b) ? 32'd1 : 32'd0;
      default: return a - b;
    endcase
  endfunction

  function automatic logic cmp_ref(input ex_op_e op, input logic [XLEN-1:0] a,
                                   input logic [XLEN-1:0] b);
    case (op)
      OP_EQ:   return a == b;
      OP_NE:   return a != b;
      OP_LT:   return $signed(a) < $signed(b);
      OP_GE:   return $signed(a) >= $signed(b);
      OP_LTU:  return a < b;
      OP_GEU:  return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  // Plain writing issue with branch and CSR fields cleared
  function automatic ex_issue_t build_issue(input ex_op_e op, input logic [XLEN-1:0] a,
                                            input logic [XLEN-1:0] b,
                                            input logic [REG_ADDR_W-1:0] wa);
    ex_issue_t it;
    it           = '0;
    it.op        = op;
    it.operand_a = a;
    it.operand_b = b;
    it.waddr     = wa;
    it.we        = 1'b1;
    return it;
  endfunction

  function automatic logic [XLEN-1:0] rand_word();
    return $random(seed);
  endfunction

  function automatic logic [REG_ADDR_W-1:0] rand_reg();
    logic [XLEN-1:0] r;
    r = $random(seed);
    return r[REG_ADDR_W-1:0];
  endfunction

  //////////////////////////////////////////////////
  // Driving and checking
  //////////////////////////////////////////////////

  task automatic check_eq(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp,
                          input string what);
    if (!timed_out)
    begin
      assert (got === exp)
      else
      begin
        $display("mismatch at time %0t: %s, got %h, expected %h", $time, what, got, exp);
        errors++;
      end
    end
  endtask

  // Back to a point just after the next rising edge
  task automatic next_cycle();
    @(posedge clk);
    #DRIVE_DLY;
  endtask

  // Hold the issue until accepted and count cycles spent waiting
  // Also counts cycles where a result leaves EX
  task automatic send_issue(input ex_issue_t it, output int waited, output int fired);
    waited        = 0;
    fired         = 0;
    issue_i       = it;
    issue_valid_i = 1'b1;
    @(negedge clk);
    while (!ex_ready_o && !timed_out)
    begin
      waited++;
      if (ex_valid_o)
        fired++;
      if (waited > READY_TIMEOUT)
      begin
        $display("timed out at time %0t waiting for ex_ready_o to rise", $time);
        timed_out = 1'b1;
      end
      else
        @(negedge clk);
    end
    if (ex_valid_o)
      fired++;
    // Accepting edge
    next_cycle();
    issue_valid_i = 1'b0;
  endtask

  task automatic read_check(input logic [REG_ADDR_W-1:0] addr);
    raddr_i = addr;
    @(negedge clk);
    check_eq(rdata_o, model_regs[addr], $sformatf("register x%0d", addr));
    next_cycle();
  endtask

  task automatic check_all_regs();
    for (int i = 0; i < NUM_REGS; i++)
      read_check(REG_ADDR_W'(i));
  endtask

  task automatic check_blocked(input string when);
    @(negedge clk);
    check_eq(XLEN'(ex_ready_o), '0, {"ex_ready_o ", when});
    check_eq(XLEN'(ex_valid_o), '0, {"ex_valid_o ", when});
  endtask

  task automatic start_test();
    test_start_errors = errors;
  endtask

  task automatic finish_test(input string name);
    if (errors == test_start_errors && !timed_out)
    begin
      tests_passed++;
      $display("test %s: passed", name);
    end
    else
    begin
      tests_failed++;
      $display("test %s: failed, %0d mismatches", name, errors - test_start_errors);
    end
  endtask

  //////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////

  task automatic test_reset();
    start_test();
    @(negedge clk);
    check_eq(XLEN'(ex_ready_o), 32'd1, "ex_ready_o after reset");
    check_eq(XLEN'(ex_valid_o), '0, "ex_valid_o after reset");
    next_cycle();
    check_all_regs();
    finish_test("reset state");
  endtask

  task automatic test_alu();
    logic [XLEN-1:0]       a;
    logic [XLEN-1:0]       b;
    logic [REG_ADDR_W-1:0] wa;
    int                    waited;
    int                    fired;
    start_test();
    for (int n = 0; n < 40; n++)
    begin
      a  = rand_word();
      b  = rand_word();
      // Every eighth write aims at x0
      wa = (n % 8 == 0) ? '0 : rand_reg();
      send_issue(build_issue(ALU_OPS[n % 10], a, b, wa), waited, fired);
      check_eq(XLEN'(fired), 32'd1, "cycles with ex_valid_o high for ALU op");
      if (wa != '0)
        model_regs[wa] = alu_ref(ALU_OPS[n % 10], a, b);
      next_cycle();
      read_check(wa);
    end
    finish_test("random ALU operations");
  endtask

  task automatic test_mul();
    logic [XLEN-1:0]       a;
    logic [XLEN-1:0]       b;
    logic [XLEN-1:0]       c;
    logic [REG_ADDR_W-1:0] mul_wa;
    logic [REG_ADDR_W-1:0] alu_wa;
    int                    waited;
    int                    fired;
    start_test();
    for (int n = 0; n < 4; n++)
    begin
      a      = rand_word();
      // All ones multiplier adds on every step
      b      = (n == 0) ? '1 : rand_word();
      c      = rand_word();
      mul_wa = rand_reg() | 5'd1;
      alu_wa = mul_wa ^ 5'd2;
      send_issue(build_issue(OP_MUL, a, b, mul_wa), waited, fired);
      // ALU op queued right behind the multiply
      send_issue(build_issue(OP_XOR, a, c, alu_wa), waited, fired);
      check_eq(XLEN'(waited), XLEN'(MULT_STEPS + 1), "cycles with ex_ready_o low");
      // Multiply result leaves first, then the ALU op
      check_eq(XLEN'(fired), 32'd2, "cycles with ex_valid_o high after multiply");
      // Low word of the product
      model_regs[mul_wa] = a * b;
      model_regs[alu_wa] = alu_ref(OP_XOR, a, c);
      next_cycle();
      read_check(mul_wa);
      read_check(alu_wa);
    end
    finish_test("sequential multiply");
  endtask

  task automatic test_branch();
    ex_issue_t       it;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    start_test();
    for (int n = 0; n < 12; n++)
    begin
      a = rand_word();
      // Odd passes compare equal operands
      b = (n % 2 == 1) ? a : rand_word();
      it = build_issue(CMP_OPS[n / 2], a, b, rand_reg() | 5'd1);
      it.is_branch  = 1'b1;
      it.operand_c  = rand_word();
      // Every third pass stalls so only the branch term keeps ready high
      stall_i       = (n % 3 == 0);
      issue_i       = it;
      issue_valid_i = 1'b1;
      @(negedge clk);
      check_eq(XLEN'(branch_decision_o), XLEN'(cmp_ref(it.op, a, b)), "branch decision");
      check_eq(jump_target_o, it.operand_c, "jump target");
      check_eq(XLEN'(ex_ready_o), 32'd1, "ex_ready_o for branch");
      next_cycle();
      issue_valid_i = 1'b0;
    end
    stall_i = 1'b0;
    next_cycle();
    // Nothing written by branches
    check_all_regs();
    finish_test("branch comparisons");
  endtask

  task automatic test_csr();
    ex_issue_t             it;
    logic [REG_ADDR_W-1:0] wa;
    int                    waited;
    int                    fired;
    start_test();
    for (int n = 0; n < 6; n++)
    begin
      wa = rand_reg();
      it = build_issue(ALU_OPS[n], rand_word(), rand_word(), wa);
      it.csr_access = 1'b1;
      it.csr_rdata  = rand_word();
      send_issue(it, waited, fired);
      check_eq(XLEN'(fired), 32'd1, "cycles with ex_valid_o high for CSR op");
      if (wa != '0)
        model_regs[wa] = it.csr_rdata;
      next_cycle();
      read_check(wa);
    end
    finish_test("CSR read select");
  endtask

  task automatic test_stall();
    ex_issue_t             it;
    logic [XLEN-1:0]       a;
    logic [XLEN-1:0]       b;
    logic [REG_ADDR_W-1:0] wa;
    logic [REG_ADDR_W-1:0] mul_wa;
    int                    waited;
    int                    fired;
    start_test();
    a      = rand_word();
    b      = rand_word();
    wa     = rand_reg() | 5'd1;
    mul_wa = wa ^ 5'd2;
    // ALU issue blocked by downstream
    it            = build_issue(OP_ADD, a, b, wa);
    stall_i       = 1'b1;
    issue_i       = it;
    issue_valid_i = 1'b1;
    for (int n = 0; n < 6; n++)
      check_blocked("under stall");
    next_cycle();
    read_check(wa);
    stall_i = 1'b0;
    send_issue(it, waited, fired);
    check_eq(XLEN'(fired), 32'd1, "cycles with ex_valid_o high after stall");
    model_regs[wa] = alu_ref(OP_ADD, a, b);
    next_cycle();
    read_check(wa);
    // Multiply completes while stalled
    send_issue(build_issue(OP_MUL, a, b, mul_wa), waited, fired);
    stall_i = 1'b1;
    for (int n = 0; n < MULT_STEPS + 8; n++)
      check_blocked("with multiply under stall");
    next_cycle();
    check_all_regs();
    stall_i = 1'b0;
    send_issue(build_issue(OP_OR, a, b, wa), waited, fired);
    check_eq(XLEN'(fired), 32'd2, "cycles with ex_valid_o high after stalled multiply");
    model_regs[mul_wa] = a * b;
    model_regs[wa]     = alu_ref(OP_OR, a, b);
    next_cycle();
    read_check(mul_wa);
    read_check(wa);
    finish_test("downstream stall");
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial
  begin
    rst_n         = 1'b0;
    issue_valid_i = 1'b0;
    issue_i       = '0;
    stall_i       = 1'b0;
    raddr_i       = '0;
    errors        = 0;
    tests_passed  = 0;
    tests_failed  = 0;
    timed_out     = 1'b0;
    for (int i = 0; i < NUM_REGS; i++)
      model_regs[i] = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DLY;
    rst_n = 1'b1;

    test_reset();
    if (!timed_out)
      test_alu();
    if (!timed_out)
      test_mul();
    if (!timed_out)
      test_branch();
    if (!timed_out)
      test_csr();
    if (!timed_out)
      test_stall();

    $display("tests passed: %0d, tests failed: %0d, mismatches: %0d",
             tests_passed, tests_failed, errors);
    if (errors == 0 && tests_failed == 0 && !timed_out)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

endmodule

`default_nettype wire
